//--- lenet_fc.f
+incdir+source
+incdir+sim
source/lenet_fc_pkg.sv
source/fc_iterator.sv
source/fc_param_rom.sv
source/fc_mac.sv
source/argmax_digit.sv
source/lenet_fc.sv
sim/tb_lenet_fc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lenet_fc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lenet_fc \
	-f lenet_fc.f --Mdir obj_dir -o tb_lenet_fc
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_lenet_fc
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0

//--- sim/tb_lenet_fc_model.svh
// reference model of the fully connected stage
// weights, biases, class scores and the strict arg-max,
// worked out from the layer formulas over the image in img
`ifndef TB_LENET_FC_MODEL_SVH
`define TB_LENET_FC_MODEL_SVH

// low byte of c*37 + k*11 + 5, read as signed
function automatic int pixel_weight(input int c, input int k);
	int v;
	v = (c * 37 + k * 11 + 5) & 255;
	if (v >= 128)
		v = v - 256;
	return v;
endfunction

function automatic int class_score(input int c);
	int sum;
	sum = 0;
	for (int k = 0; k < `FC_INPUTS; k++)
		sum = sum + int'(img[k]) * pixel_weight(c, k);
	// shift the full sum, then add the class bias
	return (sum >>> `FC_WEIGHT_SHIFT) + c * 16 - 80;
endfunction

// strict compare, so a tie keeps the lower class
function automatic int best_class();
	int best;
	int top;
	best = 0;
	top = class_score(0);
	for (int c = 1; c < `FC_CLASSES; c++) begin
		if (class_score(c) > top) begin
			top = class_score(c);
			best = c;
		end
	end
	return best;
endfunction

function automatic bit top_is_tied();
	int d;
	int top;
	d = best_class();
	top = class_score(d);
	for (int c = d + 1; c < `FC_CLASSES; c++)
		if (class_score(c) == top)
			return 1'b1;
	return 1'b0;
endfunction

`endif

//--- sim/tb_lenet_fc.sv
// testbench for the fully connected LeNet output stage
// random, zero, tied and disturbed images checked against a model
`timescale 1ns/1ps
`default_nettype none

`include "lenet_fc_macros.svh"

module tb_lenet_fc import lenet_fc_pkg::*; ();

	localparam int RUN_CYCLES = `FC_CLASSES * `FC_INPUTS + 3;
	localparam int TIMEOUT    = 2 * RUN_CYCLES;
	// halfway through the class 9 reads
	localparam int POKE_AT    = (`FC_CLASSES - 1) * `FC_INPUTS + `FC_INPUTS / 2;

	logic      clk;
	logic      reset_i;
	logic      go_i;
	logic      src_rd_o;
	src_addr_t src_addr_o;
	pixel_t    src_data_i;
	class_t    digit_o;
	logic      ready_o;
	pixel_t    img [`FC_INPUTS];
	pixel_t    saved [`FC_INPUTS];
	logic      pend_rd;
	src_addr_t pend_addr;
	int        rd_count;

	`include "tb_lenet_fc_model.svh"

	lenet_fc i_dut (
		.clk        (clk),
		.reset_i    (reset_i),
		.go_i       (go_i),
		.src_rd_o   (src_rd_o),
		.src_addr_o (src_addr_o),
		.src_data_i (src_data_i),
		.digit_o    (digit_o),
		.ready_o    (ready_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// source memory, answers the read seen at the previous falling edge
	// reads must walk the inputs in order, once per class
	always @(negedge clk) begin
		if (pend_rd)
			src_data_i <= img[pend_addr];
		if (src_rd_o === 1'b1) begin
			compare_value("src_addr_o", rd_count % `FC_INPUTS, src_addr_o);
			rd_count <= rd_count + 1;
		end
		pend_rd   <= src_rd_o;
		pend_addr <= src_addr_o;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name,
				expected, actual);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one run, optionally with a disturbed image and a stray go mid-run
	task automatic run_image(input int gap, input bit poke);
		int exp_digit;
		int n;
		int reads_before;
		exp_digit = best_class();
		reads_before = rd_count;
		go_i = 1'b1;
		@(negedge clk);
		go_i = 1'b0;
		compare_value("digit_o", 0, digit_o);
		n = 0;
		while (!ready_o) begin
			if (n > TIMEOUT) begin
				$display("no ready_o pulse within %0d cycles of go_i", TIMEOUT);
				$display("tests failed");
				$fatal(1, "timeout");
			end
			go_i = 1'b0;
			if (poke && n == POKE_AT) begin
				// only pixels class 9 has already read
				for (int k = 0; k < `FC_INPUTS / 4; k++)
					img[k] = ~img[k];
				go_i = 1'b1;
			end
			@(negedge clk);
			n++;
		end
		compare_value("latency", RUN_CYCLES, n);
		compare_value("src_rd_o reads", `FC_CLASSES * `FC_INPUTS, rd_count - reads_before);
		compare_value("digit_o", exp_digit, digit_o);
		repeat (gap + 1) begin
			@(negedge clk);
			compare_value("ready_o", 0, ready_o);
			compare_value("src_rd_o", 0, src_rd_o);
			compare_value("digit_o", exp_digit, digit_o);
		end
	endtask

	initial begin
		bit found;
		void'($urandom(32'hf544));
		reset_i = 1'b1;
		go_i = 1'b0;
		src_data_i = '0;
		pend_rd = 1'b0;
		pend_addr = '0;
		rd_count = 0;
		for (int k = 0; k < `FC_INPUTS; k++)
			img[k] = '0;
		repeat (2) @(negedge clk);
		reset_i = 1'b0;
		compare_value("ready_o", 0, ready_o);
		compare_value("src_rd_o", 0, src_rd_o);
		compare_value("digit_o", 0, digit_o);

		for (int i = 0; i < 20; i++) begin
			for (int k = 0; k < `FC_INPUTS; k++)
				img[k] = pixel_t'($urandom);
			run_image($urandom_range(0, 4), 1'b0);
		end

		// biases alone decide, class 9 has the largest
		for (int k = 0; k < `FC_INPUTS; k++)
			img[k] = '0;
		compare_value("model digit", 9, best_class());
		run_image(2, 1'b0);

		// raise one pixel until two classes share the top score
		found = 1'b0;
		for (int p = 1; p < 2000 && !found; p++) begin
			img[0] = pixel_t'(p);
			found = top_is_tied();
		end
		if (!found) begin
			$display("no pixel value gives a tie at the top score");
			$display("tests failed");
			$fatal(1, "tie search");
		end
		run_image(2, 1'b0);

		for (int k = 0; k < `FC_INPUTS; k++)
			img[k] = pixel_t'($urandom);
		saved = img;
		run_image(1, 1'b1);
		img = saved;

		for (int i = 0; i < 5; i++) begin
			for (int k = 0; k < `FC_INPUTS; k++)
				img[k] = pixel_t'($urandom);
			run_image(0, 1'b0);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/argmax_digit.sv
// arg-max over the class scores
// keeps the running maximum and its class, latches the digit
// on the last class and pulses ready one cycle after
`timescale 1ns/1ps
`default_nettype none

`include "lenet_fc_macros.svh"

module argmax_digit import lenet_fc_pkg::*; (
	input  wire       clk,
	input  wire       reset_i,
	input  wire       start_i,
	input  fc_score_t score_i,
	output class_t    digit_o,
	output logic      ready_o
);

	acc_t   max_q;
	class_t best_q;
	class_t digit_q;
	logic   done_q;
	logic   ready_q;
	logic   take_new;
	logic   last_cls;

	// class 0 always seeds the maximum, ties keep the lower index
	assign take_new = score_i.valid &&
		(score_i.class_idx == '0 || score_i.score > max_q);
	assign last_cls = score_i.valid &&
		(score_i.class_idx == class_t'(`FC_CLASSES - 1));

	always_ff @(posedge clk) begin
		if (reset_i || start_i) begin
			max_q   <= '0;
			best_q  <= '0;
			digit_q <= '0;
		end else begin
			if (take_new) begin
				max_q  <= score_i.score;
				best_q <= score_i.class_idx;
			end
			if (last_cls)
				digit_q <= take_new ? score_i.class_idx : best_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			done_q  <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			done_q  <= last_cls;
			ready_q <= done_q;
		end
	end

	assign digit_o = digit_q;
	assign ready_o = ready_q;

endmodule

`default_nettype wire

//--- source/fc_iterator.sv
// fully connected run controller
// walks all classes and inputs, one read per cycle, and issues
// the control strobes one cycle behind each read
`timescale 1ns/1ps
`default_nettype none

`include "lenet_fc_macros.svh"

module fc_iterator import lenet_fc_pkg::*; (
	input  wire       clk,
	input  wire       reset_i,
	input  wire       go_i,
	output logic      src_rd_o,
	output src_addr_t src_addr_o,
	output class_t    class_o,
	output logic      busy_o,
	output fc_ctrl_t  ctrl_o
);

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} state_t;

	state_t    state_q;
	src_addr_t idx_q;
	class_t    cls_q;
	fc_ctrl_t  ctrl_q;
	logic      run;
	logic      idx_end;
	logic      cls_end;

	assign run     = (state_q == ST_RUN);
	assign idx_end = (idx_q == src_addr_t'(`FC_INPUTS - 1));
	assign cls_end = (cls_q == class_t'(`FC_CLASSES - 1));

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			idx_q   <= '0;
			cls_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (go_i) begin
						state_q <= ST_RUN;
						idx_q   <= '0;
						cls_q   <= '0;
					end
				end
				ST_RUN: begin
					idx_q <= idx_end ? '0 : idx_q + 1'b1;
					if (idx_end) begin
						cls_q <= cls_end ? '0 : cls_q + 1'b1;
						// last read of the last class
						if (cls_end)
							state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// one cycle late, lines up with the memory outputs
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q.en        <= run;
			ctrl_q.first     <= run && (idx_q == '0);
			ctrl_q.last      <= run && idx_end;
			ctrl_q.class_idx <= cls_q;
		end
	end

	assign src_rd_o   = run;
	assign src_addr_o = idx_q;
	assign class_o    = cls_q;
	assign busy_o     = run;
	assign ctrl_o     = ctrl_q;

endmodule

`default_nettype wire

//--- source/fc_mac.sv
// multiply-accumulate for one class score
// sums pixel*weight over the inputs, then shifts and adds the bias
`timescale 1ns/1ps
`default_nettype none

`include "lenet_fc_macros.svh"

module fc_mac import lenet_fc_pkg::*; (
	input  wire       clk,
	input  wire       reset_i,
	input  fc_ctrl_t  ctrl_i,
	input  pixel_t    pixel_i,
	input  weight_t   weight_i,
	input  bias_t     bias_i,
	output fc_score_t score_o
);

	acc_t   acc_q;
	acc_t   prod;
	acc_t   sum_next;
	logic   valid_q;
	class_t class_q;
	acc_t   score_q;

	assign prod     = acc_t'(pixel_i) * acc_t'(weight_i);
	// first product restarts the sum
	assign sum_next = (ctrl_i.first ? acc_t'(0) : acc_q) + prod;

	always_ff @(posedge clk) begin
		if (ctrl_i.en)
			acc_q <= sum_next;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			valid_q <= 1'b0;
		else
			valid_q <= ctrl_i.en && ctrl_i.last;
	end

	always_ff @(posedge clk) begin
		if (ctrl_i.en && ctrl_i.last) begin
			class_q <= ctrl_i.class_idx;
			score_q <= (sum_next >>> `FC_WEIGHT_SHIFT) + acc_t'(bias_i);
		end
	end

	assign score_o.valid     = valid_q;
	assign score_o.class_idx = class_q;
	assign score_o.score     = score_q;

endmodule

`default_nettype wire

//--- source/fc_param_rom.sv
// weight and bias ROM for the fully connected layer
// registered read, contents from the package formulas,
// outputs hold while no read is issued
`timescale 1ns/1ps
`default_nettype none

module fc_param_rom import lenet_fc_pkg::*; (
	input  wire       clk,
	input  wire       rd_i,
	input  class_t    class_i,
	input  src_addr_t index_i,
	output weight_t   weight_o,
	output bias_t     bias_o
);

	weight_t weight_q;
	bias_t   bias_q;

	always_ff @(posedge clk) begin
		if (rd_i) begin
			weight_q <= fc_weight(class_i, index_i);
			// same bias for every input of a class
			bias_q   <= fc_bias(class_i);
		end
	end

	assign weight_o = weight_q;
	assign bias_o   = bias_q;

endmodule

`default_nettype wire

//--- source/lenet_fc.sv
// fully connected LeNet output stage
// one FC layer over an 8x8 image from external memory,
// followed by the arg-max digit decision
`timescale 1ns/1ps
`default_nettype none

module lenet_fc import lenet_fc_pkg::*; (
	input  wire       clk,
	input  wire       reset_i,
	input  wire       go_i,
	output logic      src_rd_o,
	output src_addr_t src_addr_o,
	input  pixel_t    src_data_i,
	output class_t    digit_o,
	output logic      ready_o
);

	class_t    class_idx;
	logic      busy;
	logic      start;
	fc_ctrl_t  ctrl;
	weight_t   weight;
	bias_t     bias;
	fc_score_t score;

	// a go while busy is dropped here and in the iterator alike
	assign start = go_i && !busy;

	fc_iterator i_iterator (
		.clk        (clk),
		.reset_i    (reset_i),
		.go_i       (go_i),
		.src_rd_o   (src_rd_o),
		.src_addr_o (src_addr_o),
		.class_o    (class_idx),
		.busy_o     (busy),
		.ctrl_o     (ctrl)
	);

	fc_param_rom i_param_rom (
		.clk      (clk),
		.rd_i     (src_rd_o),
		.class_i  (class_idx),
		.index_i  (src_addr_o),
		.weight_o (weight),
		.bias_o   (bias)
	);

	fc_mac i_mac (
		.clk      (clk),
		.reset_i  (reset_i),
		.ctrl_i   (ctrl),
		.pixel_i  (src_data_i),
		.weight_i (weight),
		.bias_i   (bias),
		.score_o  (score)
	);

	argmax_digit i_argmax (
		.clk     (clk),
		.reset_i (reset_i),
		.start_i (start),
		.score_i (score),
		.digit_o (digit_o),
		.ready_o (ready_o)
	);

endmodule

`default_nettype wire

//--- source/lenet_fc_macros.svh
// fully connected classifier constants
// sizes of the layer, datapath widths and the post-sum weight shift
`ifndef LENET_FC_MACROS_SVH
`define LENET_FC_MACROS_SVH

// output classes, one per digit
`define FC_CLASSES      10
// pixels of one 8x8 image
`define FC_INPUTS       64

`define FC_DATA_W       16
`define FC_WEIGHT_W     8
`define FC_BIAS_W       16
`define FC_ACC_W        32

// arithmetic right shift of a finished sum before the bias
`define FC_WEIGHT_SHIFT 4

`endif

//--- source/lenet_fc_pkg.sv
// fully connected classifier types
// vector typedefs, control and score structs, weight and bias formulas
`default_nettype none

`include "lenet_fc_macros.svh"

package lenet_fc_pkg;

	typedef logic signed [`FC_DATA_W-1:0]   pixel_t;
	typedef logic signed [`FC_WEIGHT_W-1:0] weight_t;
	typedef logic signed [`FC_BIAS_W-1:0]   bias_t;
	typedef logic signed [`FC_ACC_W-1:0]    acc_t;
	typedef logic [$clog2(`FC_INPUTS)-1:0]  src_addr_t;
	typedef logic [$clog2(`FC_CLASSES)-1:0] class_t;

	// strobes in step with the memory data
	typedef struct packed {
		logic   en;
		logic   first;
		logic   last;
		class_t class_idx;
	} fc_ctrl_t;

	typedef struct packed {
		logic   valid;
		class_t class_idx;
		acc_t   score;
	} fc_score_t;

	// low byte of c*37 + k*11 + 5, taken as signed
	function automatic weight_t fc_weight(input class_t c, input src_addr_t k);
		int v;
		v = int'(c) * 37 + int'(k) * 11 + 5;
		return weight_t'(v[`FC_WEIGHT_W-1:0]);
	endfunction

	function automatic bias_t fc_bias(input class_t c);
		int v;
		v = int'(c) * 16 - 80;
		return bias_t'(v);
	endfunction

endpackage

`default_nettype wire
